//--- logic/biu_defs.svh
`ifndef BIU_DEFS_SVH
`define BIU_DEFS_SVH

// bus widths
`define BIU_ADDR_W 32
`define BIU_DATA_W 32
`define BIU_ID_W 4

// read ids, one per requester
`define BIU_ID_FETCH 4'd0
`define BIU_ID_LANE1 4'd1
`define BIU_ID_LANE2 4'd2

// arlen values, beats minus one
`define BIU_FETCH_LEN 4'd1
`define BIU_DATA_LEN 4'd0

`endif

//--- logic/biu_pkg.sv
`include "biu_defs.svh"

package biu_pkg;

	typedef logic [`BIU_ADDR_W-1:0] addr_t;
	typedef logic [`BIU_DATA_W-1:0] word_t;
	typedef logic [`BIU_DATA_W/8-1:0] strb_t;
	typedef logic [`BIU_ID_W-1:0] axi_id_t;

	// same encoding as axsize
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

	typedef enum logic {
		KIND_LOAD  = 1'b0,
		KIND_STORE = 1'b1
	} mem_kind_t;

	// inst_lo sits at the fetch pc, inst_hi at pc+4
	typedef struct packed {
		word_t inst_hi;
		word_t inst_lo;
	} inst_pair_t;

endpackage

//--- logic/mem_request_slots.sv
`timescale 1ns/100ps

module mem_request_slots (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  lane1_valid,
	input  biu_pkg::mem_kind_t    lane1_kind,
	input  biu_pkg::addr_t        lane1_addr,
	input  biu_pkg::access_size_t lane1_size,
	input  biu_pkg::word_t        lane1_wdata,
	input  logic                  lane2_valid,
	input  biu_pkg::mem_kind_t    lane2_kind,
	input  biu_pkg::addr_t        lane2_addr,
	input  biu_pkg::access_size_t lane2_size,
	input  biu_pkg::word_t        lane2_wdata,
	output logic                  lane1_ready,
	output logic                  lane2_ready,
	output logic                  lane1_rvalid,
	output biu_pkg::word_t        lane1_rdata,
	output logic                  lane2_rvalid,
	output biu_pkg::word_t        lane2_rdata,
	output logic                  mem_stall,
	output logic                  rd1_req,
	output biu_pkg::addr_t        rd1_addr,
	output biu_pkg::access_size_t rd1_size,
	output logic                  rd2_req,
	output biu_pkg::addr_t        rd2_addr,
	output biu_pkg::access_size_t rd2_size,
	output logic                  wr1_req,
	output logic                  wr2_req,
	output biu_pkg::addr_t        wr1_addr,
	output biu_pkg::access_size_t wr1_size,
	output biu_pkg::word_t        wr1_wdata,
	output biu_pkg::addr_t        wr2_addr,
	output biu_pkg::access_size_t wr2_size,
	output biu_pkg::word_t        wr2_wdata,
	input  logic                  rd1_done,
	input  biu_pkg::word_t        rd1_data,
	input  logic                  rd2_done,
	input  biu_pkg::word_t        rd2_data,
	input  logic                  wr1_done,
	input  logic                  wr2_done
);
	import biu_pkg::*;

	logic         occ1;
	logic         occ2;
	logic         fwd2;
	mem_kind_t    kind1;
	mem_kind_t    kind2;
	addr_t        addr1;
	addr_t        addr2;
	access_size_t size1;
	access_size_t size2;
	word_t        wdata1;
	word_t        wdata2;
	logic         accept1;
	logic         accept2;
	logic         fwd_new;
	logic         fwd_held;
	logic         fwd_hit;
	logic         fwd_done;
	word_t        fwd_word;

	assign accept1 = lane1_valid && lane1_ready;
	assign accept2 = lane2_valid && lane2_ready;

	//////////////////////////////
	// store to load forwarding
	//////////////////////////////

	// store arriving with the load, or already parked in slot 1
	assign fwd_new  = accept1 && lane1_kind == KIND_STORE && lane1_addr == lane2_addr;
	assign fwd_held = occ1 && kind1 == KIND_STORE && addr1 == lane2_addr;
	assign fwd_hit  = accept2 && lane2_kind == KIND_LOAD && (fwd_new || fwd_held);
	assign fwd_word = fwd_new ? lane1_wdata : wdata1;
	// forwarded load retires one cycle after it is parked
	assign fwd_done = occ2 && fwd2;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			occ1 <= 1'b0;
			occ2 <= 1'b0;
			fwd2 <= 1'b0;
			lane1_rvalid <= 1'b0;
			lane2_rvalid <= 1'b0;
		end
		else
		begin
			lane1_rvalid <= rd1_done;
			lane2_rvalid <= rd2_done || fwd_done;
			if (accept1)
				occ1 <= 1'b1;
			else if (rd1_done || wr1_done)
				occ1 <= 1'b0;
			if (accept2)
			begin
				occ2 <= 1'b1;
				fwd2 <= fwd_hit;
			end
			else if (rd2_done || wr2_done || fwd_done)
				occ2 <= 1'b0;
		end
	end

	// request payload and returned load data
	always_ff @(posedge clk)
	begin
		if (accept1)
		begin
			kind1  <= lane1_kind;
			addr1  <= lane1_addr;
			size1  <= lane1_size;
			wdata1 <= lane1_wdata;
		end
		if (accept2)
		begin
			kind2  <= lane2_kind;
			addr2  <= lane2_addr;
			size2  <= lane2_size;
			wdata2 <= fwd_hit ? fwd_word : lane2_wdata;
		end
		if (rd1_done)
			lane1_rdata <= rd1_data;
		if (rd2_done)
			lane2_rdata <= rd2_data;
		else if (fwd_done)
			lane2_rdata <= wdata2;
	end

	assign lane1_ready = !occ1;
	assign lane2_ready = !occ2;
	assign mem_stall   = occ1 || occ2;

	assign rd1_req   = occ1 && kind1 == KIND_LOAD;
	assign rd1_addr  = addr1;
	assign rd1_size  = size1;
	assign wr1_req   = occ1 && kind1 == KIND_STORE;
	assign wr1_addr  = addr1;
	assign wr1_size  = size1;
	assign wr1_wdata = wdata1;

	// a forwarded load never reaches the read controller
	assign rd2_req   = occ2 && kind2 == KIND_LOAD && !fwd2;
	assign rd2_addr  = addr2;
	assign rd2_size  = size2;
	assign wr2_req   = occ2 && kind2 == KIND_STORE;
	assign wr2_addr  = addr2;
	assign wr2_size  = size2;
	assign wr2_wdata = wdata2;

	// completions from the channel controllers only hit live slots
	assert property (@(posedge clk) disable iff (reset)
		(rd1_done || wr1_done) |-> occ1);
	assert property (@(posedge clk) disable iff (reset)
		(rd2_done || wr2_done) |-> occ2 && !fwd2);

endmodule

//--- logic/read_channel_ctrl.sv
`timescale 1ns/100ps

`include "biu_defs.svh"

module read_channel_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fetch_valid,
	input  biu_pkg::addr_t        fetch_pc,
	output logic                  fetch_ready,
	output logic                  inst_valid,
	output biu_pkg::inst_pair_t   inst_pair,
	input  logic                  rd1_req,
	input  biu_pkg::addr_t        rd1_addr,
	input  biu_pkg::access_size_t rd1_size,
	input  logic                  rd2_req,
	input  biu_pkg::addr_t        rd2_addr,
	input  biu_pkg::access_size_t rd2_size,
	output logic                  rd1_done,
	output biu_pkg::word_t        rd1_data,
	output logic                  rd2_done,
	output biu_pkg::word_t        rd2_data,
	output biu_pkg::axi_id_t      arid,
	output biu_pkg::addr_t        araddr,
	output logic [3:0]            arlen,
	output logic [2:0]            arsize,
	output logic                  arvalid,
	input  logic                  arready,
	input  biu_pkg::axi_id_t      rid,
	input  biu_pkg::word_t        rdata,
	input  logic                  rvalid,
	input  logic                  rlast
);
	import biu_pkg::*;

	logic  busy;
	logic  fetch_open;
	logic  fetch_issued;
	logic  fetch_beat;
	addr_t fetch_pc_q;
	logic  fetch_hs;
	logic  fetch_want;
	logic  r_fetch;

	assign fetch_ready = !fetch_open;
	assign fetch_hs    = fetch_valid && fetch_ready;
	// a fetch accepted while AR is busy waits here
	assign fetch_want  = fetch_hs || (fetch_open && !fetch_issued);

	//////////////////////////////
	// read data routing by id
	//////////////////////////////

	assign r_fetch  = rvalid && rid == `BIU_ID_FETCH;
	assign rd1_done = rvalid && rid == `BIU_ID_LANE1;
	assign rd2_done = rvalid && rid == `BIU_ID_LANE2;
	assign rd1_data = rdata;
	assign rd2_data = rdata;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			arvalid <= 1'b0;
			fetch_open <= 1'b0;
			fetch_issued <= 1'b0;
			fetch_beat <= 1'b0;
			inst_valid <= 1'b0;
		end
		else
		begin
			inst_valid <= 1'b0;
			if (fetch_hs)
				fetch_open <= 1'b1;
			if (arvalid && arready)
				arvalid <= 1'b0;
			// one AR outstanding, priority fetch > lane 1 > lane 2
			if (!busy && (fetch_want || rd1_req || rd2_req))
			begin
				busy <= 1'b1;
				arvalid <= 1'b1;
				if (fetch_want)
					fetch_issued <= 1'b1;
			end
			else if (rvalid && rlast)
				busy <= 1'b0;
			if (r_fetch)
			begin
				fetch_beat <= !fetch_beat;
				if (fetch_beat)
				begin
					inst_valid <= 1'b1;
					fetch_open <= 1'b0;
					fetch_issued <= 1'b0;
				end
			end
		end
	end

	// AR payload only moves while the channel is idle
	always_ff @(posedge clk)
	begin
		if (!busy)
		begin
			if (fetch_want)
			begin
				arid   <= `BIU_ID_FETCH;
				araddr <= fetch_open ? fetch_pc_q : fetch_pc;
				arlen  <= `BIU_FETCH_LEN;
				arsize <= {1'b0, SIZE_WORD};
			end
			else if (rd1_req)
			begin
				arid   <= `BIU_ID_LANE1;
				araddr <= rd1_addr;
				arlen  <= `BIU_DATA_LEN;
				arsize <= {1'b0, rd1_size};
			end
			else
			begin
				arid   <= `BIU_ID_LANE2;
				araddr <= rd2_addr;
				arlen  <= `BIU_DATA_LEN;
				arsize <= {1'b0, rd2_size};
			end
		end
		if (fetch_hs)
			fetch_pc_q <= fetch_pc;
		// pair buffer, low word first
		if (r_fetch)
		begin
			if (fetch_beat)
				inst_pair.inst_hi <= rdata;
			else
				inst_pair.inst_lo <= rdata;
		end
	end

	// slave must end the fetch burst on beat two, data reads on beat one
	assert property (@(posedge clk) disable iff (reset)
		rvalid && !(r_fetch && !fetch_beat) |-> rlast);

endmodule

//--- logic/write_channel_ctrl.sv
`timescale 1ns/100ps

module write_channel_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr1_req,
	input  biu_pkg::addr_t        wr1_addr,
	input  biu_pkg::access_size_t wr1_size,
	input  biu_pkg::word_t        wr1_wdata,
	input  logic                  wr2_req,
	input  biu_pkg::addr_t        wr2_addr,
	input  biu_pkg::access_size_t wr2_size,
	input  biu_pkg::word_t        wr2_wdata,
	output logic                  wr1_done,
	output logic                  wr2_done,
	output biu_pkg::addr_t        awaddr,
	output logic [2:0]            awsize,
	output logic                  awvalid,
	output biu_pkg::word_t        wdata,
	output biu_pkg::strb_t        wstrb,
	output logic                  wlast,
	output logic                  wvalid,
	input  logic                  awready,
	input  logic                  wready,
	input  logic                  bvalid,
	output logic                  bready
);
	import biu_pkg::*;

	logic         busy;
	logic         sel2;
	logic         pick2;
	logic         b_hs;
	addr_t        pick_addr;
	access_size_t pick_size;

	// byte lanes from access size and low address bits
	function automatic strb_t strobe_for(input access_size_t size, input logic [1:0] offset);
		strb_t strb;
		case (size)
			SIZE_BYTE: strb = strb_t'(1) << offset;
			SIZE_HALF:
			begin
				if (offset == 2'd0)
					strb = 4'b0011;
				else if (offset == 2'd2)
					strb = 4'b1100;
				else
					strb = 4'b1111;
			end
			default: strb = 4'b1111;
		endcase
		return strb;
	endfunction

	// lane 1 first
	assign pick2     = !wr1_req;
	assign pick_addr = pick2 ? wr2_addr : wr1_addr;
	assign pick_size = pick2 ? wr2_size : wr1_size;

	assign b_hs     = bvalid && bready;
	assign wr1_done = b_hs && !sel2;
	assign wr2_done = b_hs && sel2;
	// single beat, always the last one
	assign wlast    = wvalid;

	//////////////////////////////
	// aw / w / b sequencing
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
		end
		else if (!busy && (wr1_req || wr2_req))
		begin
			busy <= 1'b1;
			awvalid <= 1'b1;
			wvalid <= 1'b1;
			bready <= 1'b1;
		end
		else
		begin
			if (awvalid && awready)
				awvalid <= 1'b0;
			if (wvalid && wready)
				wvalid <= 1'b0;
			if (b_hs)
			begin
				bready <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy)
		begin
			sel2   <= pick2;
			awaddr <= pick_addr;
			awsize <= {1'b0, pick_size};
			wdata  <= pick2 ? wr2_wdata : wr1_wdata;
			wstrb  <= strobe_for(pick_size, pick_addr[1:0]);
		end
	end

	// held valids keep their payload until the slave takes them
	assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsize));
	assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

//--- logic/bus_interface_unit.sv
`timescale 1ns/100ps

module bus_interface_unit (
	input  logic                  clk,
	input  logic                  reset,
	// instruction pair fetch
	input  logic                  fetch_valid,
	input  biu_pkg::addr_t        fetch_pc,
	output logic                  fetch_ready,
	output logic                  inst_valid,
	output biu_pkg::inst_pair_t   inst_pair,
	// load/store lanes
	input  logic                  lane1_valid,
	input  biu_pkg::mem_kind_t    lane1_kind,
	input  biu_pkg::addr_t        lane1_addr,
	input  biu_pkg::access_size_t lane1_size,
	input  biu_pkg::word_t        lane1_wdata,
	input  logic                  lane2_valid,
	input  biu_pkg::mem_kind_t    lane2_kind,
	input  biu_pkg::addr_t        lane2_addr,
	input  biu_pkg::access_size_t lane2_size,
	input  biu_pkg::word_t        lane2_wdata,
	output logic                  lane1_ready,
	output logic                  lane2_ready,
	output logic                  lane1_rvalid,
	output biu_pkg::word_t        lane1_rdata,
	output logic                  lane2_rvalid,
	output biu_pkg::word_t        lane2_rdata,
	output logic                  mem_stall,
	// AXI read
	output biu_pkg::axi_id_t      arid,
	output biu_pkg::addr_t        araddr,
	output logic [3:0]            arlen,
	output logic [2:0]            arsize,
	output logic                  arvalid,
	input  logic                  arready,
	input  biu_pkg::axi_id_t      rid,
	input  biu_pkg::word_t        rdata,
	input  logic                  rvalid,
	input  logic                  rlast,
	// AXI write
	output biu_pkg::addr_t        awaddr,
	output logic [2:0]            awsize,
	output logic                  awvalid,
	input  logic                  awready,
	output biu_pkg::word_t        wdata,
	output biu_pkg::strb_t        wstrb,
	output logic                  wlast,
	output logic                  wvalid,
	input  logic                  wready,
	input  logic                  bvalid,
	output logic                  bready
);
	import biu_pkg::*;

	// slot bank to read controller
	logic         rd1_req;
	addr_t        rd1_addr;
	access_size_t rd1_size;
	logic         rd2_req;
	addr_t        rd2_addr;
	access_size_t rd2_size;
	logic         rd1_done;
	word_t        rd1_data;
	logic         rd2_done;
	word_t        rd2_data;

	// slot bank to write controller
	logic         wr1_req;
	addr_t        wr1_addr;
	access_size_t wr1_size;
	word_t        wr1_wdata;
	logic         wr2_req;
	addr_t        wr2_addr;
	access_size_t wr2_size;
	word_t        wr2_wdata;
	logic         wr1_done;
	logic         wr2_done;

	mem_request_slots slots (.*);

	read_channel_ctrl rd_ctrl (.*);

	write_channel_ctrl wr_ctrl (.*);

endmodule

//--- testbench/tb_bus_interface_unit.sv
`timescale 1ns/100ps

`include "biu_defs.svh"

module tb_bus_interface_unit;
	import biu_pkg::*;

	localparam int OPS_BASE = 16;
	localparam int REC_W = 6;

	logic         clk;
	logic         reset;
	logic         fetch_valid;
	addr_t        fetch_pc;
	logic         fetch_ready;
	logic         inst_valid;
	inst_pair_t   inst_pair;
	logic         lane1_valid;
	mem_kind_t    lane1_kind;
	addr_t        lane1_addr;
	access_size_t lane1_size;
	word_t        lane1_wdata;
	logic         lane2_valid;
	mem_kind_t    lane2_kind;
	addr_t        lane2_addr;
	access_size_t lane2_size;
	word_t        lane2_wdata;
	logic         lane1_ready;
	logic         lane2_ready;
	logic         lane1_rvalid;
	word_t        lane1_rdata;
	logic         lane2_rvalid;
	word_t        lane2_rdata;
	logic         mem_stall;
	axi_id_t      arid;
	addr_t        araddr;
	logic [3:0]   arlen;
	logic [2:0]   arsize;
	logic         arvalid;
	logic         arready;
	axi_id_t      rid;
	word_t        rdata;
	logic         rvalid;
	logic         rlast;
	addr_t        awaddr;
	logic [2:0]   awsize;
	logic         awvalid;
	logic         awready;
	word_t        wdata;
	strb_t        wstrb;
	logic         wlast;
	logic         wvalid;
	logic         wready;
	logic         bvalid;
	logic         bready;

	// test data and slave state
	logic [31:0]  tdata [0:255];
	logic         loaded = 1'b0;
	int           cycle_limit = 0;
	int           cycles;
	integer       seed;
	word_t        mem [0:15];
	logic         rd_pend;
	axi_id_t      rd_id;
	addr_t        rd_addr;
	int           rd_left;
	int           rd_wait;
	logic         aw_got;
	logic         w_got;
	logic         b_sched;
	int           b_wait;
	addr_t        wr_addr;
	word_t        last_wdata;
	strb_t        last_wstrb;
	logic [3:0]   last_arlen;
	logic [2:0]   last_arsize;
	logic [2:0]   last_awsize;
	axi_id_t      ar_log [$];
	int           ar_start;

	bus_interface_unit dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// failure reporting and compares
	//////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %h actual %h",
				name, expected, actual));
	endtask

	task automatic check_pair(input string name, input inst_pair_t expected,
		input inst_pair_t actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %h actual %h",
				name, expected, actual));
	endtask

	task automatic check_strb(input string name, input strb_t expected, input strb_t actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %b actual %b",
				name, expected, actual));
	endtask

	task automatic check_id(input string name, input axi_id_t expected, input axi_id_t actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	task automatic check_len(input string name, input logic [3:0] expected,
		input logic [3:0] actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	task automatic check_size(input string name, input logic [2:0] expected,
		input logic [2:0] actual);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d",
				name, expected, actual));
	endtask

	task automatic count_reads(input string name, input int n);
		if (ar_log.size() - ar_start != n)
			report_failure($sformatf("%s: expected %0d read address transfers, saw %0d",
				name, n, ar_log.size() - ar_start));
	endtask

	task automatic expect_stall(input string name);
		if (!mem_stall)
			report_failure($sformatf("%s: mem_stall low while a lane request is open", name));
	endtask

	//////////////////////////////
	// core side drivers
	//////////////////////////////

	task automatic drive_lane(input int lane, input mem_kind_t kind, input addr_t addr,
		input access_size_t size, input word_t data);
		if (lane == 1)
		begin
			lane1_valid = 1'b1;
			lane1_kind = kind;
			lane1_addr = addr;
			lane1_size = size;
			lane1_wdata = data;
		end
		else
		begin
			lane2_valid = 1'b1;
			lane2_kind = kind;
			lane2_addr = addr;
			lane2_size = size;
			lane2_wdata = data;
		end
	endtask

	task automatic release_lanes();
		lane1_valid = 1'b0;
		lane2_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (mem_stall)
			@(negedge clk);
	endtask

	task automatic fetch_pair(input string name, input addr_t pc, input word_t lo,
		input word_t hi);
		inst_pair_t expected;
		expected.inst_lo = lo;
		expected.inst_hi = hi;
		if (!fetch_ready)
			report_failure($sformatf("%s: fetch_ready low with no fetch open", name));
		fetch_valid = 1'b1;
		fetch_pc = pc;
		@(negedge clk);
		fetch_valid = 1'b0;
		if (fetch_ready)
			report_failure($sformatf("%s: fetch_ready high while a fetch is open", name));
		while (!inst_valid)
			@(negedge clk);
		check_pair(name, expected, inst_pair);
		count_reads(name, 1);
		check_id(name, `BIU_ID_FETCH, ar_log[ar_start]);
		check_len(name, `BIU_FETCH_LEN, last_arlen);
		// instruction words are four byte beats
		check_size(name, 3'd2, last_arsize);
	endtask

	task automatic load_word(input string name, input int lane, input addr_t addr,
		input access_size_t size, input word_t expected);
		drive_lane(lane, KIND_LOAD, addr, size, '0);
		@(negedge clk);
		release_lanes();
		expect_stall(name);
		while (!(lane == 1 ? lane1_rvalid : lane2_rvalid))
			@(negedge clk);
		check_word(name, expected, lane == 1 ? lane1_rdata : lane2_rdata);
		count_reads(name, 1);
		check_id(name, lane == 1 ? `BIU_ID_LANE1 : `BIU_ID_LANE2, ar_log[ar_start]);
		check_len(name, `BIU_DATA_LEN, last_arlen);
		check_size(name, 3'(size), last_arsize);
		wait_idle();
	endtask

	task automatic store_word(input string name, input int lane, input addr_t addr,
		input access_size_t size, input word_t data, input strb_t strb);
		drive_lane(lane, KIND_STORE, addr, size, data);
		@(negedge clk);
		release_lanes();
		expect_stall(name);
		wait_idle();
		check_strb(name, strb, last_wstrb);
		check_word(name, data, last_wdata);
		check_size(name, 3'(size), last_awsize);
		count_reads(name, 0);
	endtask

	// lane 1 store and lane 2 load to one address, accepted together
	task automatic forward_store(input string name, input addr_t addr,
		input access_size_t size, input word_t data, input word_t expected, input strb_t strb);
		drive_lane(1, KIND_STORE, addr, size, data);
		drive_lane(2, KIND_LOAD, addr, size, '0);
		@(negedge clk);
		release_lanes();
		expect_stall(name);
		@(negedge clk);
		if (!lane2_rvalid)
			report_failure($sformatf("%s: forwarded load missed its two cycle return", name));
		check_word(name, expected, lane2_rdata);
		wait_idle();
		check_strb(name, strb, last_wstrb);
		count_reads(name, 0);
	endtask

	task automatic load_both(input string name, input addr_t addr, input access_size_t size,
		input word_t exp1, input word_t exp2);
		logic seen1;
		logic seen2;
		drive_lane(1, KIND_LOAD, addr, size, '0);
		drive_lane(2, KIND_LOAD, addr + 4, size, '0);
		@(negedge clk);
		release_lanes();
		expect_stall(name);
		seen1 = 1'b0;
		seen2 = 1'b0;
		while (!(seen1 && seen2))
		begin
			@(negedge clk);
			if (lane1_rvalid)
			begin
				seen1 = 1'b1;
				check_word({name, " lane 1"}, exp1, lane1_rdata);
			end
			if (lane2_rvalid)
			begin
				seen2 = 1'b1;
				check_word({name, " lane 2"}, exp2, lane2_rdata);
			end
		end
		// lane 1 wins the read channel
		count_reads(name, 2);
		check_id(name, `BIU_ID_LANE1, ar_log[ar_start]);
		check_id(name, `BIU_ID_LANE2, ar_log[ar_start + 1]);
		wait_idle();
	endtask

	//////////////////////////////
	// AXI slave model
	//////////////////////////////

	initial
	begin : axi_slave
		int k;
		arready = 1'b0;
		rvalid = 1'b0;
		rid = '0;
		rdata = '0;
		rlast = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		rd_pend = 1'b0;
		aw_got = 1'b0;
		w_got = 1'b0;
		b_sched = 1'b0;
		seed = 32'h38e2ddbb;
		wait (loaded);
		for (k = 0; k < 16; k = k + 1)
			mem[k] = tdata[k];
		forever
		begin
			@(negedge clk);
			// each R beat is taken in the cycle it is shown
			rvalid = 1'b0;
			rlast = 1'b0;
			if (rd_pend)
			begin
				if (rd_wait > 0)
					rd_wait = rd_wait - 1;
				else
				begin
					rvalid = 1'b1;
					rid = rd_id;
					rdata = mem[rd_addr[5:2]];
					rlast = (rd_left == 1);
					rd_addr = rd_addr + 4;
					rd_left = rd_left - 1;
					rd_wait = $random(seed) & 1;
					rd_pend = (rd_left != 0);
				end
			end
			arready = !rd_pend && (($random(seed) & 3) != 0);
			if (arvalid && arready)
			begin
				rd_pend = 1'b1;
				rd_id = arid;
				rd_addr = araddr;
				rd_left = arlen + 1;
				rd_wait = $random(seed) & 3;
				last_arlen = arlen;
				last_arsize = arsize;
				ar_log.push_back(arid);
			end
			// B taken at the posedge after it was shown
			if (bvalid)
			begin
				bvalid = 1'b0;
				aw_got = 1'b0;
				w_got = 1'b0;
				b_sched = 1'b0;
			end
			else if (b_sched)
			begin
				if (b_wait > 0)
					b_wait = b_wait - 1;
				else if (!bready)
					report_failure("bready is low while a write response is due");
				else
					bvalid = 1'b1;
			end
			awready = !aw_got && (($random(seed) & 3) != 0);
			wready = !w_got && (($random(seed) & 3) != 0);
			if (awvalid && awready)
			begin
				aw_got = 1'b1;
				wr_addr = awaddr;
				last_awsize = awsize;
			end
			if (wvalid && wready)
			begin
				if (!wlast)
					report_failure("single beat write arrived without wlast");
				w_got = 1'b1;
				last_wdata = wdata;
				last_wstrb = wstrb;
			end
			// merge through the byte strobes
			if (aw_got && w_got && !b_sched)
			begin
				for (k = 0; k < 4; k = k + 1)
					if (last_wstrb[k])
						mem[wr_addr[5:2]][8*k +: 8] = last_wdata[8*k +: 8];
				b_sched = 1'b1;
				b_wait = $random(seed) & 3;
			end
		end
	end

	initial
	begin : watchdog
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycle_limit != 0 && cycles > cycle_limit)
				report_failure($sformatf("timeout after %0d cycles, the DUT stopped responding",
					cycles));
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin : stimulus
		int i;
		int n_ops;
		int base;
		int op;
		string name;
		addr_t addr;
		access_size_t size;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		lane1_kind = KIND_LOAD;
		lane1_addr = '0;
		lane1_size = SIZE_WORD;
		lane1_wdata = '0;
		lane2_kind = KIND_LOAD;
		lane2_addr = '0;
		lane2_size = SIZE_WORD;
		lane2_wdata = '0;
		release_lanes();
		ar_start = 0;
		for (i = 0; i < 256; i = i + 1)
			tdata[i] = '0;
		$readmemh("testbench/biu_testdata.txt", tdata);
		n_ops = 0;
		while (n_ops < 39 && tdata[OPS_BASE + REC_W * n_ops] != 0)
			n_ops = n_ops + 1;
		// reset counts as one more operation
		cycle_limit = 200 * (n_ops + 1);
		loaded = 1'b1;

		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (!(fetch_ready && lane1_ready && lane2_ready))
			report_failure("ready outputs are not all high after reset");
		if (mem_stall || arvalid || awvalid || wvalid || bready || inst_valid
			|| lane1_rvalid || lane2_rvalid)
			report_failure("a valid, bready or mem_stall output is high after reset");

		for (i = 0; i < n_ops; i = i + 1)
		begin
			base = OPS_BASE + REC_W * i;
			op = tdata[base];
			size = access_size_t'(tdata[base + 1][1:0]);
			addr = tdata[base + 2];
			name = $sformatf("op %0d code %0d", i + 1, op);
			ar_start = ar_log.size();
			case (op)
				1: fetch_pair(name, addr, tdata[base + 4], tdata[base + 5]);
				2: load_word(name, 1, addr, size, tdata[base + 4]);
				3: load_word(name, 2, addr, size, tdata[base + 4]);
				4: store_word(name, 1, addr, size, tdata[base + 3], tdata[base + 4][3:0]);
				5: store_word(name, 2, addr, size, tdata[base + 3], tdata[base + 4][3:0]);
				6: forward_store(name, addr, size, tdata[base + 3], tdata[base + 4],
					tdata[base + 5][3:0]);
				7: load_both(name, addr, size, tdata[base + 4], tdata[base + 5]);
				default: report_failure($sformatf("%s: unknown operation code", name));
			endcase
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+logic
logic/biu_pkg.sv
logic/mem_request_slots.sv
logic/read_channel_ctrl.sv
logic/write_channel_ctrl.sv
logic/bus_interface_unit.sv
testbench/tb_bus_interface_unit.sv

//--- Makefile
# Verilator build and run for the bus interface unit testbench

VERILATOR ?= verilator
TOP ?= tb_bus_interface_unit
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the binary exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/biu_testdata.txt
// words 0x00-0x0f: memory image for byte addresses 0x00 to 0x3c
// from @10, one operation per line: op size addr wdata exp0 exp1
// op 1 fetch, 2/3 lane 1/2 load, 4/5 lane 1/2 store, 6 store+load forward, 7 both loads, 0 end
@00
3c011000 24210004 8c220000 ac230004
11111111 22222222 33333333 44444444
a5a5a5a5 5a5a5a5a deadbeef cafef00d
01234567 89abcdef 0f0f0f0f f0f0f0f0
@10
1 2 00000000 00000000 3c011000 24210004
1 2 00000008 00000000 8c220000 ac230004
2 2 00000010 00000000 11111111 00000000
3 2 00000014 00000000 22222222 00000000
// stores, exp0 is the expected wstrb
4 0 00000019 0000ab00 00000002 00000000
5 1 0000001e beef0000 0000000c 00000000
4 0 00000020 000000cc 00000001 00000000
4 0 00000023 77000000 00000008 00000000
5 0 00000026 00990000 00000004 00000000
4 1 00000028 00001234 00000003 00000000
4 2 0000002c 600dcafe 0000000f 00000000
// merged words read back
2 2 00000018 00000000 3333ab33 00000000
3 2 0000001c 00000000 beef4444 00000000
2 2 00000020 00000000 77a5a5cc 00000000
3 2 00000024 00000000 5a995a5a 00000000
2 2 00000028 00000000 dead1234 00000000
3 2 0000002c 00000000 600dcafe 00000000
// exp0 forwarded word, exp1 store strobe
6 2 00000030 feedface feedface 0000000f
7 2 00000034 00000000 89abcdef 0f0f0f0f
3 2 00000030 00000000 feedface 00000000
1 2 00000018 00000000 3333ab33 beef4444
0 0 00000000 00000000 00000000 00000000
